// ==== logic/core_cfg_pkg.sv ====
package core_cfg_pkg;

    localparam int XLEN = 32;
    localparam int INSTS_PER_FETCH = 2;
    localparam int BUNDLE_BYTES = 8;

    typedef logic [XLEN-1:0] addr_t;

    // insts[0] sits at pc, insts[1] at pc + 4
    typedef struct packed {
        addr_t                                pc;
        logic [INSTS_PER_FETCH-1:0][XLEN-1:0] insts;
    } fetch_bundle_t;

    // one request per late stage, writeback has top priority
    typedef struct packed {
        logic  wb_valid;
        logic  ex_valid;
        logic  id_valid;
        addr_t wb_target;
        addr_t ex_target;
        addr_t id_target;
    } pc_redirect_t;

endpackage

// ==== logic/axi_rd_pkg.sv ====
package axi_rd_pkg;

    localparam int AXI_ID_W = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_WORD = 3'b010;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

endpackage

// ==== logic/fetch_pc_unit.sv ====
module fetch_pc_unit (
    input  logic                       i_aclk,
    input  logic                       i_aresetn,
    input  core_cfg_pkg::pc_redirect_t i_redirect,
    input  logic                       i_issue_ready,
    output core_cfg_pkg::addr_t        o_pc,
    output logic                       o_flush
);
    import core_cfg_pkg::*;

    logic  redirect_any;
    addr_t redirect_target;

    assign redirect_any = i_redirect.wb_valid || i_redirect.ex_valid || i_redirect.id_valid;

    // writeback over execute over decode
    always_comb begin
        redirect_target = i_redirect.id_target;
        if (i_redirect.wb_valid) begin
            redirect_target = i_redirect.wb_target;
        end else if (i_redirect.ex_valid) begin
            redirect_target = i_redirect.ex_target;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_pc    <= '0;
            o_flush <= 1'b0;
        end else begin
            o_flush <= redirect_any;
            if (redirect_any) begin
                o_pc <= redirect_target;
            end else if (i_issue_ready) begin
                o_pc <= o_pc + addr_t'(BUNDLE_BYTES);
            end
        end
    end

    // bundles are fetched whole, so a target must start one
    a_target_aligned : assert property (
        @(posedge i_aclk) disable iff (!i_aresetn)
        redirect_any |-> (redirect_target[2:0] == 3'b000)
    );

endmodule

// ==== logic/fetch_read_engine.sv ====
module fetch_read_engine (
    input  logic                        i_aclk,
    input  logic                        i_aresetn,
    input  core_cfg_pkg::addr_t         i_pc,
    input  logic                        i_flush,
    input  logic                        i_buf_full,
    input  logic                        i_ar_ready,
    input  axi_rd_pkg::axi_r_t          i_r,
    input  logic                        i_r_valid,
    output logic                        o_issue_ready,
    output axi_rd_pkg::axi_ar_t         o_ar,
    output logic                        o_ar_valid,
    output logic                        o_r_ready,
    output core_cfg_pkg::fetch_bundle_t o_bundle,
    output logic                        o_bundle_valid
);
    import core_cfg_pkg::*;
    import axi_rd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_COLLECT,
        ST_DROP
    } state_t;

    state_t          state_q;
    addr_t           pc_q;
    logic [XLEN-1:0] inst0_q;
    logic            beat_q;
    logic            drop_q;
    logic            r_fire;
    logic            last_fire;

    assign o_issue_ready = (state_q == ST_IDLE) && !i_buf_full;
    assign o_ar_valid = (state_q == ST_REQ);
    assign o_r_ready = (state_q == ST_COLLECT) || (state_q == ST_DROP);
    assign r_fire = i_r_valid && o_r_ready;
    assign last_fire = r_fire && i_r.last;

    // one bundle per burst, fetch id is always 0
    always_comb begin
        o_ar.id    = '0;
        o_ar.addr  = pc_q;
        o_ar.len   = 8'(INSTS_PER_FETCH - 1);
        o_ar.size  = SIZE_WORD;
        o_ar.burst = BURST_INCR;
    end

    // second word goes straight from the bus into the bundle
    always_comb begin
        o_bundle.pc       = pc_q;
        o_bundle.insts[0] = inst0_q;
        o_bundle.insts[1] = i_r.data;
    end

    assign o_bundle_valid = (state_q == ST_COLLECT) && last_fire && beat_q && !i_flush;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            state_q <= ST_IDLE;
            beat_q  <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (o_issue_ready) begin
                        state_q <= ST_REQ;
                        beat_q  <= 1'b0;
                        drop_q  <= 1'b0;
                    end
                end
                ST_REQ: begin
                    // request must stay up until accepted, even when stale
                    if (i_ar_ready) begin
                        state_q <= (drop_q || i_flush) ? ST_DROP : ST_COLLECT;
                    end else if (i_flush) begin
                        drop_q <= 1'b1;
                    end
                end
                ST_COLLECT: begin
                    if (r_fire) begin
                        beat_q <= !beat_q;
                    end
                    if (last_fire) begin
                        state_q <= ST_IDLE;
                    end else if (i_flush) begin
                        state_q <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (r_fire) begin
                        beat_q <= !beat_q;
                    end
                    if (last_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (o_issue_ready) begin
            pc_q <= i_pc;
        end
        if ((state_q == ST_COLLECT) && r_fire && !beat_q) begin
            inst0_q <= i_r.data;
        end
    end

    // slave must end every fetch burst on its second beat
    a_last_on_beat1 : assert property (
        @(posedge i_aclk) disable iff (!i_aresetn)
        r_fire |-> (i_r.last == beat_q)
    );

endmodule

// ==== logic/fetch_buffer.sv ====
module fetch_buffer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        i_aclk,
    input  logic                        i_aresetn,
    input  logic                        i_flush,
    input  logic                        i_push,
    input  core_cfg_pkg::fetch_bundle_t i_data,
    input  logic                        i_pop,
    output core_cfg_pkg::fetch_bundle_t o_data,
    output logic                        o_valid,
    output logic                        o_full
);
    import core_cfg_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fetch_bundle_t    mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // wraps at any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_full = (count_q == CNT_W'(FIFO_DEPTH));
    assign o_valid = (count_q != '0);
    assign o_data = mem[rd_ptr_q];
    assign do_push = i_push && !o_full;
    assign do_pop = i_pop && o_valid;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn || i_flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

    // the engine only issues with room left for its bundle
    a_no_push_full : assert property (
        @(posedge i_aclk) disable iff (!i_aresetn)
        i_push |-> !o_full
    );

    a_no_pop_empty : assert property (
        @(posedge i_aclk) disable iff (!i_aresetn)
        i_pop |-> o_valid
    );

endmodule

// ==== logic/axi_read_arbiter.sv ====
module axi_read_arbiter #(
    parameter int MASTER_BIT = 3
) (
    input  logic                i_aclk,
    input  logic                i_aresetn,
    input  axi_rd_pkg::axi_ar_t i_f_ar,
    input  logic                i_f_ar_valid,
    input  logic                i_f_r_ready,
    input  axi_rd_pkg::axi_ar_t i_d_ar,
    input  logic                i_d_ar_valid,
    input  logic                i_d_r_ready,
    input  logic                i_m_ar_ready,
    input  axi_rd_pkg::axi_r_t  i_m_r,
    input  logic                i_m_r_valid,
    output logic                o_f_ar_ready,
    output axi_rd_pkg::axi_r_t  o_f_r,
    output logic                o_f_r_valid,
    output logic                o_d_ar_ready,
    output axi_rd_pkg::axi_r_t  o_d_r,
    output logic                o_d_r_valid,
    output axi_rd_pkg::axi_ar_t o_m_ar,
    output logic                o_m_ar_valid,
    output logic                o_m_r_ready
);
    import axi_rd_pkg::*;

    // select encoding: 0 fetch, 1 data
    logic   grant_q;
    logic   grant_sel_q;
    logic   last_sel_q;
    logic   pick;
    logic   sel;
    logic   route_d;
    axi_r_t r_clean;

    always_comb begin
        if (i_f_ar_valid && i_d_ar_valid) begin
            pick = !last_sel_q;
        end else begin
            pick = i_d_ar_valid;
        end
    end

    // a stalled request keeps its grant
    assign sel = grant_q ? grant_sel_q : pick;

    assign o_m_ar_valid = sel ? i_d_ar_valid : i_f_ar_valid;
    assign o_f_ar_ready = i_m_ar_ready && !sel;
    assign o_d_ar_ready = i_m_ar_ready && sel;

    always_comb begin
        o_m_ar = sel ? i_d_ar : i_f_ar;
        o_m_ar.id[MASTER_BIT] = sel;
    end

    // responses come back by the tag bit
    assign route_d = i_m_r.id[MASTER_BIT];

    always_comb begin
        r_clean = i_m_r;
        r_clean.id[MASTER_BIT] = 1'b0;
    end

    assign o_f_r = r_clean;
    assign o_d_r = r_clean;
    assign o_f_r_valid = i_m_r_valid && !route_d;
    assign o_d_r_valid = i_m_r_valid && route_d;
    assign o_m_r_ready = route_d ? i_d_r_ready : i_f_r_ready;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            grant_q     <= 1'b0;
            grant_sel_q <= 1'b0;
            last_sel_q  <= 1'b1;
        end else if (o_m_ar_valid) begin
            if (i_m_ar_ready) begin
                grant_q    <= 1'b0;
                last_sel_q <= sel;
            end else begin
                grant_q     <= 1'b1;
                grant_sel_q <= sel;
            end
        end
    end

    // both masters must hold a waiting request
    a_ar_held : assert property (
        @(posedge i_aclk) disable iff (!i_aresetn)
        (o_m_ar_valid && !i_m_ar_ready) |=> (o_m_ar_valid && $stable(o_m_ar))
    );

endmodule

// ==== logic/fetch_front_top.sv ====
module fetch_front_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MASTER_BIT = 3
) (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  core_cfg_pkg::pc_redirect_t  i_redirect,
    input  logic                        i_fetch_pop,
    input  axi_rd_pkg::axi_ar_t         i_data_ar,
    input  logic                        i_data_ar_valid,
    input  logic                        i_data_r_ready,
    input  logic                        i_axi_ar_ready,
    input  axi_rd_pkg::axi_r_t          i_axi_r,
    input  logic                        i_axi_r_valid,
    output core_cfg_pkg::fetch_bundle_t o_fetch,
    output logic                        o_fetch_valid,
    output logic                        o_data_ar_ready,
    output axi_rd_pkg::axi_r_t          o_data_r,
    output logic                        o_data_r_valid,
    output axi_rd_pkg::axi_ar_t         o_axi_ar,
    output logic                        o_axi_ar_valid,
    output logic                        o_axi_r_ready
);
    import core_cfg_pkg::*;
    import axi_rd_pkg::*;

    addr_t         pc;
    logic          flush;
    logic          issue_ready;
    logic          buf_full;
    fetch_bundle_t bundle;
    logic          bundle_valid;

    // fetch side of the arbiter
    axi_ar_t f_ar;
    logic    f_ar_valid;
    logic    f_ar_ready;
    axi_r_t  f_r;
    logic    f_r_valid;
    logic    f_r_ready;

    fetch_pc_unit u_pc (
        .i_aclk        (aclk),
        .i_aresetn     (aresetn),
        .i_redirect    (i_redirect),
        .i_issue_ready (issue_ready),
        .o_pc          (pc),
        .o_flush       (flush)
    );

    fetch_read_engine u_engine (
        .i_aclk         (aclk),
        .i_aresetn      (aresetn),
        .i_pc           (pc),
        .i_flush        (flush),
        .i_buf_full     (buf_full),
        .i_ar_ready     (f_ar_ready),
        .i_r            (f_r),
        .i_r_valid      (f_r_valid),
        .o_issue_ready  (issue_ready),
        .o_ar           (f_ar),
        .o_ar_valid     (f_ar_valid),
        .o_r_ready      (f_r_ready),
        .o_bundle       (bundle),
        .o_bundle_valid (bundle_valid)
    );

    fetch_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .i_aclk    (aclk),
        .i_aresetn (aresetn),
        .i_flush   (flush),
        .i_push    (bundle_valid),
        .i_data    (bundle),
        .i_pop     (i_fetch_pop),
        .o_data    (o_fetch),
        .o_valid   (o_fetch_valid),
        .o_full    (buf_full)
    );

    axi_read_arbiter #(
        .MASTER_BIT (MASTER_BIT)
    ) u_arbiter (
        .i_aclk       (aclk),
        .i_aresetn    (aresetn),
        .i_f_ar       (f_ar),
        .i_f_ar_valid (f_ar_valid),
        .i_f_r_ready  (f_r_ready),
        .i_d_ar       (i_data_ar),
        .i_d_ar_valid (i_data_ar_valid),
        .i_d_r_ready  (i_data_r_ready),
        .i_m_ar_ready (i_axi_ar_ready),
        .i_m_r        (i_axi_r),
        .i_m_r_valid  (i_axi_r_valid),
        .o_f_ar_ready (f_ar_ready),
        .o_f_r        (f_r),
        .o_f_r_valid  (f_r_valid),
        .o_d_ar_ready (o_data_ar_ready),
        .o_d_r        (o_data_r),
        .o_d_r_valid  (o_data_r_valid),
        .o_m_ar       (o_axi_ar),
        .o_m_ar_valid (o_axi_ar_valid),
        .o_m_r_ready  (o_axi_r_ready)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
module axi_mem_model (
    input  logic                aclk,
    input  logic                aresetn,
    input  axi_rd_pkg::axi_ar_t i_ar,
    input  logic                i_ar_valid,
    output logic                o_ar_ready,
    output axi_rd_pkg::axi_r_t  o_r,
    output logic                o_r_valid,
    input  logic                i_r_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    import axi_rd_pkg::*;

    axi_ar_t     req_q[$];
    logic [7:0]  beat;
    logic        r_fire_q;
    logic [31:0] rng_state;
    logic [31:0] rnd;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // handshakes complete on the rising edge
    always @(posedge aclk) begin
        if (!aresetn) begin
            req_q.delete();
            beat = 8'd0;
            r_fire_q = 1'b0;
        end else begin
            if (i_ar_valid && o_ar_ready) begin
                req_q.push_back(i_ar);
            end
            r_fire_q = o_r_valid && i_r_ready;
            if (r_fire_q) begin
                if (o_r.last) begin
                    void'(req_q.pop_front());
                    beat = 8'd0;
                end else begin
                    beat = beat + 8'd1;
                end
            end
        end
    end

    // outputs change on the falling edge only
    initial begin
        rng_state = 32'ha07d;
        o_ar_ready = 1'b0;
        o_r_valid = 1'b0;
        o_r = '0;
        forever begin
            @(negedge aclk);
            rng_state = xorshift32(rng_state);
            rnd = rng_state;
            if (!aresetn) begin
                o_ar_ready = 1'b0;
                o_r_valid = 1'b0;
            end else begin
                o_ar_ready = (rnd[1:0] != 2'b00);
                // a shown beat stays until taken
                if (!o_r_valid || r_fire_q) begin
                    if ((req_q.size() != 0) && (rnd[3:2] != 2'b00)) begin
                        o_r_valid = 1'b1;
                        o_r.id = req_q[0].id;
                        o_r.data = ~(req_q[0].addr + {22'd0, beat, 2'b00});
                        o_r.resp = 2'b00;
                        o_r.last = (beat == req_q[0].len);
                    end else begin
                        o_r_valid = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== sim/tb_fetch_front.sv ====
module tb_fetch_front;
    timeunit 1ns;
    timeprecision 1ps;

    import core_cfg_pkg::*;
    import axi_rd_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int MASTER_BIT = 3;
    localparam int WAIT_LIMIT = 2000;

    logic          aclk = 1'b0;
    logic          aresetn;
    pc_redirect_t  redirect;
    logic          fetch_pop;
    axi_ar_t       data_ar;
    logic          data_ar_valid;
    logic          data_r_ready;
    logic          axi_ar_ready;
    axi_r_t        axi_r;
    logic          axi_r_valid;
    fetch_bundle_t fetch;
    logic          fetch_valid;
    logic          data_ar_ready;
    axi_r_t        data_r;
    logic          data_r_valid;
    axi_ar_t       axi_ar;
    logic          axi_ar_valid;
    logic          axi_r_ready;

    int          mismatch_count = 0;
    int          other_count = 0;
    int          fetch_ar_count = 0;
    int          fetch_last_count = 0;
    int          pop_count = 0;
    addr_t       exp_pc;
    logic [31:0] rng_state;
    event        timed_out;

    always #5 aclk = ~aclk;

    fetch_front_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MASTER_BIT (MASTER_BIT)
    ) DUT (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_redirect      (redirect),
        .i_fetch_pop     (fetch_pop),
        .i_data_ar       (data_ar),
        .i_data_ar_valid (data_ar_valid),
        .i_data_r_ready  (data_r_ready),
        .i_axi_ar_ready  (axi_ar_ready),
        .i_axi_r         (axi_r),
        .i_axi_r_valid   (axi_r_valid),
        .o_fetch         (fetch),
        .o_fetch_valid   (fetch_valid),
        .o_data_ar_ready (data_ar_ready),
        .o_data_r        (data_r),
        .o_data_r_valid  (data_r_valid),
        .o_axi_ar        (axi_ar),
        .o_axi_ar_valid  (axi_ar_valid),
        .o_axi_r_ready   (axi_r_ready)
    );

    axi_mem_model u_mem (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar       (axi_ar),
        .i_ar_valid (axi_ar_valid),
        .o_ar_ready (axi_ar_ready),
        .o_r        (axi_r),
        .o_r_valid  (axi_r_valid),
        .i_r_ready  (axi_r_ready)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // memory answers each word address with its inverse
    function automatic fetch_bundle_t bundle_at(input addr_t pc);
        fetch_bundle_t b;
        b.pc = pc;
        b.insts[0] = ~pc;
        b.insts[1] = ~(pc + 32'd4);
        return b;
    endfunction

    function automatic axi_ar_t fetch_ar_rule();
        axi_ar_t a;
        a.id = '0;
        a.addr = '0;
        a.len = 8'd1;
        a.size = SIZE_WORD;
        a.burst = BURST_INCR;
        return a;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatch_count++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp);
        if (got.pc !== exp.pc) begin
            report_mismatch("o_fetch.pc", got.pc, exp.pc);
        end
        if (got.insts[0] !== exp.insts[0]) begin
            report_mismatch("o_fetch.insts[0]", got.insts[0], exp.insts[0]);
        end
        if (got.insts[1] !== exp.insts[1]) begin
            report_mismatch("o_fetch.insts[1]", got.insts[1], exp.insts[1]);
        end
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t exp);
        if (got.id !== exp.id) begin
            report_mismatch("o_data_r.id", 32'(got.id), 32'(exp.id));
        end
        if (got.data !== exp.data) begin
            report_mismatch("o_data_r.data", got.data, exp.data);
        end
        if (got.resp !== exp.resp) begin
            report_mismatch("o_data_r.resp", 32'(got.resp), 32'(exp.resp));
        end
        if (got.last !== exp.last) begin
            report_mismatch("o_data_r.last", 32'(got.last), 32'(exp.last));
        end
    endtask

    task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
        if (got.id !== exp.id) begin
            report_mismatch("o_axi_ar.id", 32'(got.id), 32'(exp.id));
        end
        if (got.addr[2:0] !== exp.addr[2:0]) begin
            report_mismatch("o_axi_ar.addr[2:0]", 32'(got.addr[2:0]), 32'(exp.addr[2:0]));
        end
        if (got.len !== exp.len) begin
            report_mismatch("o_axi_ar.len", 32'(got.len), 32'(exp.len));
        end
        if (got.size !== exp.size) begin
            report_mismatch("o_axi_ar.size", 32'(got.size), 32'(exp.size));
        end
        if (got.burst !== exp.burst) begin
            report_mismatch("o_axi_ar.burst", 32'(got.burst), 32'(exp.burst));
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        other_count++;
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
        -> timed_out;
        forever @(negedge aclk);
    endtask

    // fetch bursts seen on the external port
    always @(posedge aclk) begin
        if (aresetn && axi_ar_valid && axi_ar_ready && !axi_ar.id[MASTER_BIT]) begin
            fetch_ar_count++;
            check_ar(axi_ar, fetch_ar_rule());
        end
        if (aresetn && axi_r_valid && axi_r_ready && axi_r.last && !axi_r.id[MASTER_BIT]) begin
            fetch_last_count++;
        end
    end

    // called on a falling edge, returns on one
    task automatic pop_bundle(output fetch_bundle_t b);
        int waited;
        waited = 0;
        while (!fetch_valid) begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("a fetch bundle");
            end
        end
        b = fetch;
        fetch_pop = 1'b1;
        pop_count++;
        @(negedge aclk);
        fetch_pop = 1'b0;
    endtask

    task automatic check_next_bundles(input int n);
        fetch_bundle_t b;
        repeat (n) begin
            pop_bundle(b);
            check_bundle(b, bundle_at(exp_pc));
            exp_pc = exp_pc + 32'd8;
        end
    endtask

    task automatic apply_redirect(input pc_redirect_t r);
        redirect = r;
        @(negedge aclk);
        redirect = '0;
        // buffer is empty after the flush edge
        @(negedge aclk);
    endtask

    task automatic data_read();
        axi_ar_t     req;
        axi_r_t      got;
        axi_r_t      exp;
        logic [31:0] rnd;
        logic        done;
        int          waited;
        rnd = next_rand();
        req.id = rnd[3:0];
        req.addr = next_rand() & 32'h0000_fffc;
        req.len = 8'd0;
        req.size = SIZE_WORD;
        req.burst = BURST_INCR;
        data_ar = req;
        data_ar_valid = 1'b1;
        done = 1'b0;
        waited = 0;
        while (!done) begin
            @(posedge aclk);
            done = data_ar_ready;
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("data AR ready");
            end
        end
        data_ar_valid = 1'b0;
        got = '0;
        done = 1'b0;
        waited = 0;
        while (!done) begin
            rnd = next_rand();
            data_r_ready = rnd[0];
            @(posedge aclk);
            if (data_r_valid && data_r_ready) begin
                done = 1'b1;
                got = data_r;
            end
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("a data read response");
            end
        end
        data_r_ready = 1'b0;
        exp.id = req.id;
        exp.id[MASTER_BIT] = 1'b0;
        exp.data = ~req.addr;
        exp.resp = 2'b00;
        exp.last = 1'b1;
        check_r(got, exp);
    endtask

    task automatic sequential_fetch();
        @(negedge aclk);
        exp_pc = 32'd0;
        check_next_bundles(12);
    endtask

    task automatic back_pressure();
        int waited;
        int held;
        @(negedge aclk);
        waited = 0;
        while ((fetch_ar_count - pop_count != FIFO_DEPTH) ||
               (fetch_last_count != fetch_ar_count)) begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("the fetch buffer to fill");
            end
        end
        held = fetch_ar_count;
        repeat (40) begin
            @(negedge aclk);
            if (!fetch_valid) begin
                other_count++;
                $display("ERROR t=%0t o_fetch_valid dropped with a full buffer", $time);
            end
        end
        if (fetch_ar_count != held) begin
            other_count++;
            $display("ERROR t=%0t fetch AR issued while the buffer was full", $time);
        end
        check_next_bundles(FIFO_DEPTH + 2);
    endtask

    task automatic redirect_priority();
        pc_redirect_t r;
        @(negedge aclk);
        r = '0;
        r.id_valid = 1'b1;
        r.id_target = 32'h0000_0100;
        r.ex_valid = 1'b1;
        r.ex_target = 32'h0000_0200;
        apply_redirect(r);
        exp_pc = 32'h0000_0200;
        check_next_bundles(3);
        r.wb_valid = 1'b1;
        r.wb_target = 32'h0000_0400;
        r.ex_target = 32'h0000_0500;
        r.id_target = 32'h0000_0600;
        apply_redirect(r);
        exp_pc = 32'h0000_0400;
        check_next_bundles(3);
    endtask

    task automatic redirect_mid_read();
        pc_redirect_t r;
        int           waited;
        @(negedge aclk);
        repeat (3) begin
            // room in the buffer lets a new burst start
            check_next_bundles(1);
            waited = 0;
            while (fetch_ar_count == fetch_last_count) begin
                @(negedge aclk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("a fetch burst in flight");
                end
            end
            r = '0;
            r.ex_valid = 1'b1;
            r.ex_target = next_rand() & 32'h0000_fff8;
            apply_redirect(r);
            exp_pc = r.ex_target;
            check_next_bundles(2);
        end
    endtask

    task automatic shared_port();
        @(negedge aclk);
        fork
            begin
                repeat (8) begin
                    data_read();
                end
            end
            check_next_bundles(16);
        join
    endtask

    initial begin
        @(timed_out);
        finish_run();
    end

    initial begin
        aresetn = 1'b0;
        redirect = '0;
        fetch_pop = 1'b0;
        data_ar = '0;
        data_ar_valid = 1'b0;
        data_r_ready = 1'b0;
        exp_pc = '0;
        rng_state = 32'ha07d;
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;
        sequential_fetch();
        back_pressure();
        redirect_priority();
        redirect_mid_read();
        shared_port();
        finish_run();
    end

endmodule

// ==== sim.f ====
logic/core_cfg_pkg.sv
logic/axi_rd_pkg.sv
logic/fetch_pc_unit.sv
logic/fetch_read_engine.sv
logic/fetch_buffer.sv
logic/axi_read_arbiter.sv
logic/fetch_front_top.sv
sim/axi_mem_model.sv
sim/tb_fetch_front.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fetch_front
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
